//--- src.f
+incdir+verilog
verilog/demo_pkg.sv
verilog/panel_inputs.sv
verilog/txn_sequencer.sv
verilog/demo_panel_top.sv
bench/tb_demo_panel.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the demo panel testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_demo_panel -o tb_demo_panel \
    && ./obj_dir/tb_demo_panel 2>&1 | tee sim.log \
    || { echo "Build or simulation run error"; exit 1; }

grep -q "Regression failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation PASSED"; exit 0; }

//--- bench/tb_demo_panel.sv
// Demo panel testbench
// Master-port models, panel key and switch stimulus, checking assertions
`timescale 1ns/1ps
`include "demo_defs.svh"

module tb_demo_panel import demo_pkg::*; ();

    localparam int num_rounds = 12;
    localparam int max_steps  = 12;

    // DUT inputs start released and idle
    logic       clk      = 1'b0;
    logic       rstn     = 1'b0;
    logic [1:0] key      = 2'b11;
    logic [2:0] sw       = 3'b000;
    bus_data_t  m1_rdata = '0;
    logic       m1_ready = 1'b0;
    bus_data_t  m2_rdata = '0;
    logic       m2_ready = 1'b0;
    logic [7:0] led;
    bus_addr_t  m1_addr;
    bus_data_t  m1_wdata;
    logic       m1_mode;
    logic       m1_valid;
    bus_addr_t  m2_addr;
    bus_data_t  m2_wdata;
    logic       m2_mode;
    logic       m2_valid;

    // ========================================
    // Clock and DUT
    // ========================================
    always #20 clk = ~clk;

    demo_panel_top dut (
        .clk      (clk),
        .rstn     (rstn),
        .key      (key),
        .sw       (sw),
        .led      (led),
        .m1_addr  (m1_addr),
        .m1_wdata (m1_wdata),
        .m1_mode  (m1_mode),
        .m1_valid (m1_valid),
        .m1_rdata (m1_rdata),
        .m1_ready (m1_ready),
        .m2_addr  (m2_addr),
        .m2_wdata (m2_wdata),
        .m2_mode  (m2_mode),
        .m2_valid (m2_valid),
        .m2_rdata (m2_rdata),
        .m2_ready (m2_ready)
    );

    // ========================================
    // Expected state
    // ========================================
    int          errors      = 0;
    logic [31:0] rng         = 32'd27166;
    bus_data_t   exp_pattern = bus_data_t'(`DEMO_INIT_PATTERN);
    logic        exp_master  = 1'b0;
    slave_sel_t  exp_slave   = '0;
    logic        exp_write   = 1'b1;
    logic [7:0]  exp_led     = '0;
    bus_addr_t   exp_addr;
    // Set by a start press in idle, cleared by the request
    logic        expect_req  = 1'b0;
    logic        withhold    = 1'b0;
    logic        led_check   = 1'b0;
    logic        deadline    = 1'b0;
    int          req_count   = 0;
    int          done_count  = 0;
    int          since_req   = 0;
    int          resp_wait   = 0;
    int          led_due     = 0;
    bus_data_t   rd_data;

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Two zero bits, slave number, fixed offset
    assign exp_addr = {2'b00, exp_slave, `DEMO_MEM_ADDR_W'(`DEMO_MEM_ADDR)};

    // Muxed request view for the checks
    logic      req_valid;
    int        req_port;
    bus_addr_t req_addr;
    bus_data_t req_wdata;
    logic      req_mode;
    assign req_valid = m1_valid || m2_valid;
    assign req_port  = m2_valid ? 2 : 1;
    assign req_addr  = m2_valid ? m2_addr : m1_addr;
    assign req_wdata = m2_valid ? m2_wdata : m1_wdata;
    assign req_mode  = m2_valid ? m2_mode : m1_mode;

    // ========================================
    // Master-port models
    // ========================================
    always @(negedge clk) begin
        led_check = 1'b0;
        since_req++;
        // Request window closes once the posedge check has seen the pulse
        if (since_req == 1) begin
            expect_req = 1'b0;
        end
        if (req_valid) begin
            req_count++;
            since_req = 0;
            m1_ready  = 1'b0;
            m2_ready  = 1'b0;
            rng       = xorshift(rng);
            rd_data   = rng[7:0];
            // Ready 1 to 8 cycles after valid, never when withheld
            resp_wait = withhold ? 0 : 1 + int'(rng[10:8]);
            led_due   = 0;
            if (m2_valid) begin
                m2_rdata = rd_data;
            end else begin
                m1_rdata = rd_data;
            end
            exp_led = exp_write ? {exp_pattern[5:0], exp_slave} : {rd_data[5:0], 2'b00};
        end else if (resp_wait > 0) begin
            resp_wait--;
            if (resp_wait == 0) begin
                if (exp_master) begin
                    m2_ready = 1'b1;
                end else begin
                    m1_ready = 1'b1;
                end
                led_due = 2;
            end
        end else if (led_due > 0) begin
            // Complete state, then the display latch
            led_due--;
            if (led_due == 0) begin
                led_check = 1'b1;
                done_count++;
            end
        end
    end

    // ========================================
    // Checks
    // ========================================
    a_reset_clear: assert property (@(posedge clk)
        !rstn |-> !m1_valid && !m2_valid && led == 8'h00)
        else begin
            errors++;
            $display("Outputs not cleared during reset");
        end

    a_req_allowed: assert property (@(posedge clk) disable iff (!rstn)
        req_valid |-> expect_req)
        else begin
            errors++;
            $display("Request without a start press in idle");
        end

    a_req_port: assert property (@(posedge clk) disable iff (!rstn)
        req_valid |-> m2_valid == exp_master)
        else begin
            errors++;
            $display("Request on the unselected master port");
        end

    a_req_addr: assert property (@(posedge clk) disable iff (!rstn)
        req_valid |-> req_addr == exp_addr)
        else begin
            errors++;
            $display("Fail m%0d_addr exp %h got %h", req_port, exp_addr, $sampled(req_addr));
        end

    a_req_mode: assert property (@(posedge clk) disable iff (!rstn)
        req_valid |-> req_mode == exp_write)
        else begin
            errors++;
            $display("Fail m%0d_mode exp %h got %h", req_port, exp_write, $sampled(req_mode));
        end

    a_req_wdata: assert property (@(posedge clk) disable iff (!rstn)
        req_valid && exp_write |-> req_wdata == exp_pattern)
        else begin
            errors++;
            $display("Fail m%0d_wdata exp %h got %h", req_port, exp_pattern,
                     $sampled(req_wdata));
        end

    a_led_value: assert property (@(posedge clk) disable iff (!rstn)
        led_check || deadline |-> led == exp_led)
        else begin
            errors++;
            $display("Fail led exp %h got %h", exp_led, $sampled(led));
        end

    // ========================================
    // Stimulus
    // ========================================
    // Key low 4 cycles, released 4 cycles
    task automatic press_key(input int idx);
        key[idx] = 1'b0;
        repeat (4) @(negedge clk);
        key[idx] = 1'b1;
        repeat (4) @(negedge clk);
        if (idx == 1) begin
            exp_pattern = exp_pattern + 8'd1;
        end
    endtask

    // Setting 11 on bits 2:1 reads slave 0
    task automatic set_switches(input logic [2:0] setting);
        sw         = setting;
        exp_master = setting[0];
        exp_write  = (setting[2:1] != 2'b11);
        exp_slave  = exp_write ? slave_sel_t'(setting[2:1]) : 2'b00;
        repeat (3) @(negedge clk);
    endtask

    task automatic wait_request(input int reqs);
        int waited;
        waited = 0;
        while (req_count == reqs && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (req_count == reqs) begin
            errors++;
            $display("No request on either master port after the start press");
        end
        // Back on the falling edge for the next key drive
        @(negedge clk);
    endtask

    task automatic run_txn(input logic [2:0] setting);
        int reqs;
        int dones;
        int waited;
        set_switches(setting);
        reqs       = req_count;
        dones      = done_count;
        expect_req = 1'b1;
        press_key(0);
        wait_request(reqs);
        waited = 0;
        while (done_count == dones && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (done_count == dones) begin
            errors++;
            $display("Transaction never completed after ready");
        end
        @(negedge clk);
    endtask

    // Ready withheld, second press lands in wait
    task automatic run_timeout_txn(input logic [2:0] setting);
        int reqs;
        set_switches(setting);
        withhold   = 1'b1;
        reqs       = req_count;
        expect_req = 1'b1;
        press_key(0);
        wait_request(reqs);
        press_key(0);
        // LED sampled timeout plus 10 cycles after the valid pulse
        while (since_req < `DEMO_TXN_TIMEOUT + 8) begin
            @(posedge clk);
        end
        @(negedge clk);
        deadline = 1'b1;
        @(negedge clk);
        deadline = 1'b0;
        withhold = 1'b0;
    endtask

    initial begin
        int steps;
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        repeat (2) @(negedge clk);
        // Master 1 slave 0, master 2 slave 2, master 1 slave 1
        run_txn(3'b000);
        run_txn(3'b101);
        run_txn(3'b010);
        // Random step count before a write
        rng   = xorshift(rng);
        steps = 1 + int'(rng % max_steps);
        repeat (steps) press_key(1);
        run_txn(3'b000);
        // Read back on each port
        run_txn(3'b110);
        run_txn(3'b111);
        // Step first so the timed out write changes led
        press_key(1);
        run_timeout_txn(3'b100);
        run_txn(3'b001);
        repeat (num_rounds - 8) begin
            rng = xorshift(rng);
            if (rng[3]) begin
                press_key(1);
            end
            run_txn(rng[2:0]);
        end
        repeat (4) @(negedge clk);
        $display("Checks complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Worst case round is one full timeout
    initial begin
        repeat (num_rounds * (`DEMO_TXN_TIMEOUT + 100)) @(posedge clk);
        $display("Watchdog expired before the tests ended, %0d errors", errors);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- verilog/demo_panel_top.sv
// Demo panel top level
// Input conditioning feeding the transaction sequencer
`timescale 1ns/1ps

module demo_panel_top import demo_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic [1:0] key,
    input  logic [2:0] sw,
    output logic [7:0] led,
    // Master port 1 device side
    output bus_addr_t  m1_addr,
    output bus_data_t  m1_wdata,
    output logic       m1_mode,
    output logic       m1_valid,
    input  bus_data_t  m1_rdata,
    input  logic       m1_ready,
    // Master port 2 device side
    output bus_addr_t  m2_addr,
    output bus_data_t  m2_wdata,
    output logic       m2_mode,
    output logic       m2_valid,
    input  bus_data_t  m2_rdata,
    input  logic       m2_ready
);

    // Conditioned panel controls
    logic       start_press;
    logic       step_press;
    logic       master_sel;
    slave_sel_t slave_sel;
    logic       write_mode;

    panel_inputs u_inputs (
        .clk         (clk),
        .rstn        (rstn),
        .key         (key),
        .sw          (sw),
        .start_press (start_press),
        .step_press  (step_press),
        .master_sel  (master_sel),
        .slave_sel   (slave_sel),
        .write_mode  (write_mode)
    );

    txn_sequencer u_seq (
        .clk         (clk),
        .rstn        (rstn),
        .start_press (start_press),
        .step_press  (step_press),
        .master_sel  (master_sel),
        .slave_sel   (slave_sel),
        .write_mode  (write_mode),
        .m1_addr     (m1_addr),
        .m1_wdata    (m1_wdata),
        .m1_mode     (m1_mode),
        .m1_valid    (m1_valid),
        .m1_rdata    (m1_rdata),
        .m1_ready    (m1_ready),
        .m2_addr     (m2_addr),
        .m2_wdata    (m2_wdata),
        .m2_mode     (m2_mode),
        .m2_valid    (m2_valid),
        .m2_rdata    (m2_rdata),
        .m2_ready    (m2_ready),
        .led         (led)
    );

endmodule

//--- verilog/txn_sequencer.sv
// One-shot transaction sequencer
// Pattern counter, request FSM with timeout and LED status latch
`timescale 1ns/1ps
`include "demo_defs.svh"

module txn_sequencer import demo_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    // From panel conditioning
    input  logic       start_press,
    input  logic       step_press,
    input  logic       master_sel,
    input  slave_sel_t slave_sel,
    input  logic       write_mode,
    // Master port 1 device side
    output bus_addr_t  m1_addr,
    output bus_data_t  m1_wdata,
    output logic       m1_mode,
    output logic       m1_valid,
    input  bus_data_t  m1_rdata,
    input  logic       m1_ready,
    // Master port 2 device side
    output bus_addr_t  m2_addr,
    output bus_data_t  m2_wdata,
    output logic       m2_mode,
    output logic       m2_valid,
    input  bus_data_t  m2_rdata,
    input  logic       m2_ready,
    // Status display
    output logic [7:0] led
);

    // ========================================
    // Data pattern
    // ========================================
    bus_data_t pattern;

    // Wraps at 256
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pattern <= bus_data_t'(`DEMO_INIT_PATTERN);
        end else if (step_press) begin
            pattern <= pattern + 1'b1;
        end
    end

    // ========================================
    // Captured request settings
    // ========================================
    demo_state_e                state;
    logic [`DEMO_TIMEOUT_W-1:0] wait_cnt;
    logic                       cap_master;
    slave_sel_t                 cap_slave;
    logic                       cap_write;
    bus_data_t                  led_q;

    // Request payload, loaded in the start state
    bus_addr_t req_addr;
    bus_data_t req_wdata;
    logic      req_write;

    // Selected port's response
    logic      sel_ready;
    bus_data_t sel_rdata;
    logic      timed_out;
    bus_data_t disp_data;

    assign sel_ready = cap_master ? m2_ready : m1_ready;
    assign sel_rdata = cap_master ? m2_rdata : m1_rdata;
    assign timed_out = (wait_cnt > `DEMO_TIMEOUT_W'(`DEMO_TXN_TIMEOUT));

    // Written pattern for writes, returned data for reads
    assign disp_data = cap_write ? req_wdata : sel_rdata;

    always_ff @(posedge clk) begin
        if (state == st_start) begin
            // Two zero bits, slave number, fixed offset
            req_addr  <= {{(`DEMO_ADDR_W - `DEMO_MEM_ADDR_W - $bits(slave_sel_t)){1'b0}},
                          cap_slave, `DEMO_MEM_ADDR_W'(`DEMO_MEM_ADDR)};
            req_wdata <= pattern;
            req_write <= cap_write;
        end
    end

    // ========================================
    // Transaction FSM
    // ========================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= st_idle;
            wait_cnt   <= '0;
            cap_master <= 1'b0;
            cap_slave  <= '0;
            cap_write  <= 1'b0;
            m1_valid   <= 1'b0;
            m2_valid   <= 1'b0;
            led_q      <= '0;
        end else begin
            // Valid strobes last one cycle
            m1_valid <= 1'b0;
            m2_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (start_press) begin
                        cap_master <= master_sel;
                        cap_slave  <= slave_sel;
                        cap_write  <= write_mode;
                        state      <= st_start;
                    end
                end
                st_start: begin
                    // Only the captured port sees the request
                    m1_valid <= !cap_master;
                    m2_valid <= cap_master;
                    wait_cnt <= '0;
                    state    <= st_wait;
                end
                st_wait: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (sel_ready || timed_out) begin
                        state <= st_complete;
                    end
                end
                st_complete: begin
                    led_q <= {disp_data[5:0], cap_slave};
                    state <= st_display;
                end
                st_display: begin
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Same payload on both ports, valid picks one
    assign m1_addr  = req_addr;
    assign m1_wdata = req_wdata;
    assign m1_mode  = req_write;
    assign m2_addr  = req_addr;
    assign m2_wdata = req_wdata;
    assign m2_mode  = req_write;

    // Slave number low, data bits 5:0 high
    assign led = led_q;

    // ========================================
    // Checks
    // ========================================
    a_one_port: assert property (
        @(posedge clk) disable iff (!rstn)
        !(m1_valid && m2_valid)
    );

    // Request goes out only on the start to wait step
    a_valid_step: assert property (
        @(posedge clk) disable iff (!rstn)
        (m1_valid || m2_valid) |-> (state == st_wait) && ($past(state) == st_start)
    );

endmodule

//--- verilog/panel_inputs.sv
// Panel input conditioning
// Key synchronizers with press detection, switch synchronizer and decode
`timescale 1ns/1ps

module panel_inputs import demo_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    // Push buttons, active low
    input  logic [1:0] key,
    // Bit 0 master select, bits 2:1 slave select
    input  logic [2:0] sw,
    output logic       start_press,
    output logic       step_press,
    output logic       master_sel,
    output slave_sel_t slave_sel,
    output logic       write_mode
);

    // ========================================
    // Key press detection
    // ========================================
    // One three-stage shift register per key
    logic [1:0][2:0] key_sh;
    logic [1:0]      key_press;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            // Released keys read high
            key_sh <= '1;
        end else begin
            for (int i = 0; i < 2; i++) begin
                key_sh[i] <= {key_sh[i][1:0], key[i]};
            end
        end
    end

    // Falling edge between the two older stages
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            key_press[i] = (key_sh[i][2:1] == 2'b10);
        end
    end

    // Key 0 starts a transaction, key 1 steps the pattern
    assign start_press = key_press[0];
    assign step_press  = key_press[1];

    // ========================================
    // Switch synchronizer and decode
    // ========================================
    logic [2:0] sw_meta;
    logic [2:0] sw_sync;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sw_meta <= '0;
            sw_sync <= '0;
        end else begin
            sw_meta <= sw;
            sw_sync <= sw_meta;
        end
    end

    assign master_sel = sw_sync[0];

    // Setting 11 means read back from slave 0
    always_comb begin
        if (sw_sync[2:1] == 2'b11) begin
            slave_sel  = 2'b00;
            write_mode = 1'b0;
        end else begin
            slave_sel  = slave_sel_t'(sw_sync[2:1]);
            write_mode = 1'b1;
        end
    end

    // ========================================
    // Checks
    // ========================================
    // A held key must not retrigger the sequencer
    a_start_single: assert property (
        @(posedge clk) disable iff (!rstn)
        start_press |=> !start_press
    );

endmodule

//--- verilog/demo_pkg.sv
// Demo panel types
// Vector typedefs for bus fields and the sequencer state encoding
package demo_pkg;

    `include "demo_defs.svh"

    // Zero pad, slave select, memory offset
    typedef logic [`DEMO_ADDR_W-1:0] bus_addr_t;

    // Write data, read data and pattern
    typedef logic [`DEMO_DATA_W-1:0] bus_data_t;

    // Slave number, 0 to 2 in practice
    typedef logic [1:0] slave_sel_t;

    // Transaction sequencer states
    typedef enum logic [2:0] {
        st_idle     = 3'd0,
        st_start    = 3'd1,
        st_wait     = 3'd2,
        st_complete = 3'd3,
        st_display  = 3'd4
    } demo_state_e;

endpackage

//--- verilog/demo_defs.svh
// Demo panel shared constants
// Bus widths, fixed demo address, initial pattern and timeout
`ifndef DEMO_DEFS_SVH
`define DEMO_DEFS_SVH

// ========================================
// Bus widths
// ========================================
// Full bus address, slave select in bits 13:12
`define DEMO_ADDR_W       16
// Data width on both master ports
`define DEMO_DATA_W       8
// Address width inside one slave
`define DEMO_MEM_ADDR_W   12

// ========================================
// Demo behaviour
// ========================================
// Memory offset used by every transaction
`define DEMO_MEM_ADDR     'h010
// Pattern value after reset
`define DEMO_INIT_PATTERN 'h00
// Wait cycles before giving up on ready
`define DEMO_TXN_TIMEOUT  2000
// Wait counter width
`define DEMO_TIMEOUT_W    16

`endif
